/* build.f */
logic/trs_pkg.sv
logic/host_pkg.sv
logic/spi_link.sv
logic/cmd_parser.sv
logic/host_regs.sv
logic/io_decoder.sv
logic/esp_handshake.sv
logic/flash_spi.sv
logic/trs_io_top.sv
sim/trs_io_tb.sv

/* Makefile */
SIM       ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= trs_io_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), pass if the log holds the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/trs_io_tb.sv */
`timescale 1ns/1ps

module trs_io_tb
  import trs_pkg::*, host_pkg::*;
();

  localparam int ESP_REQ_CYCLES         = 50;
  localparam int FLASH_HALF_CYCLES_LOG2 = 3;
  localparam int CLK_PERIOD             = 4;
  localparam int SPI_HALF               = 8;  // clk cycles per sck half period
  localparam logic [31:0] SEED          = 32'hed54_de6e;

  // cycle budget of each activity summed over all tests
  localparam int XFER_CYCLES  = 2 * 8 * SPI_HALF + SPI_HALF + 8;
  localparam int IO_CYCLES    = ESP_REQ_CYCLES + 24;
  localparam int FLASH_CYCLES = 16 << FLASH_HALF_CYCLES_LOG2;
  localparam int TEST_CYCLES  = 20 + 21 * XFER_CYCLES + 6 * IO_CYCLES + 2 * FLASH_CYCLES;
  localparam int WATCHDOG_NS  = 2 * TEST_CYCLES * CLK_PERIOD;

  logic        clk = 1'b0;
  logic        rst;
  logic        sck, cs_n, mosi, miso, miso_oe;
  logic [15:0] addr;
  logic        in_n, out_n, ioreq_n;
  logic [7:0]  bus_d_in, bus_d_out;
  logic        bus_d_oe, extiosel;
  logic [3:0]  conf, esp_s, led;
  logic        esp_req, esp_done, bus_wait, bus_int;
  logic [2:0]  led_rgb;
  logic        flash_cs_n, flash_sck, flash_si;
  logic        flash_so = 1'b0;

  // flash model state
  logic [7:0]  flash_byte = 8'h00;
  logic [7:0]  si_bits = 8'h00;
  logic        sck_prev = 1'b0;
  int          so_idx = 0;
  int          si_cnt = 0;

  // bus observations from the last z80 cycle
  logic [3:0]  cap_esp_s;
  logic [3:0]  cap_led;
  logic [7:0]  cap_data;
  logic        cap_oe, cap_ext;
  int          wait_delay, req_len, done_lat;

  logic [7:0]  exp_q [$];
  logic [7:0]  got_q [$];
  string       name_q [$];

  trs_io_top #(
    .ESP_REQ_CYCLES(ESP_REQ_CYCLES),
    .FLASH_HALF_CYCLES_LOG2(FLASH_HALF_CYCLES_LOG2)
  ) dut_i (
    .clk(clk), .rst(rst), .sck(sck), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .miso_oe(miso_oe), .addr(addr), .in_n(in_n), .out_n(out_n), .ioreq_n(ioreq_n),
    .bus_d_in(bus_d_in), .bus_d_out(bus_d_out), .bus_d_oe(bus_d_oe), .conf(conf),
    .esp_s(esp_s), .esp_req(esp_req), .esp_done(esp_done), .bus_wait(bus_wait),
    .bus_int(bus_int), .extiosel(extiosel), .led(led), .led_rgb(led_rgb),
    .flash_cs_n(flash_cs_n), .flash_sck(flash_sck), .flash_si(flash_si),
    .flash_so(flash_so)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // serial flash model shifting msb first on so and recording si at each sck rise
  always @(negedge clk) begin
    if (flash_cs_n) begin
      so_idx = 0;
      si_cnt = 0;
    end else begin
      if (flash_sck && !sck_prev) begin
        si_bits = {si_bits[6:0], flash_si};
        si_cnt++;
      end
      if (!flash_sck && sck_prev)
        so_idx++;
    end
    sck_prev = flash_sck;
    flash_so = (so_idx < 8) ? flash_byte[7 - so_idx] : 1'b0;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic abort_run(input string what);
    $display("ERROR: %s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  // spi replies are compared here as they arrive
  always @(posedge clk) begin
    while (got_q.size() > 0)
      check(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
  end

  // expected reply to a finished command as the esp reads it in the next frame
  function automatic logic [7:0] expected_reply(input logic [7:0] op, input logic [3:0] cfg,
                                                input logic [7:0] bus_byte,
                                                input logic [15:0] abus);
    case (op)
      cmd_get_cookie:  return 8'hAF;
      cmd_get_version: return {3'd0, 5'd3};  // major then minor
      cmd_get_config:  return {4'h0, cfg};
      cmd_dbus_read:   return bus_byte;
      cmd_abus_read:   return abus[7:0];
      default:         return 8'h00;
    endcase
  endfunction

  // mode 0 master with miso read late in each low phase
  task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
    rx   = 8'h00;
    cs_n = 1'b0;
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      repeat (SPI_HALF) @(negedge clk);
      if (i != 7)
        rx = {rx[6:0], miso};
      else
        check("miso_oe in frame", 1, miso_oe);
      sck = 1'b1;
      repeat (SPI_HALF) @(negedge clk);
      sck = 1'b0;
    end
    repeat (SPI_HALF) @(negedge clk);
    rx   = {rx[6:0], miso};
    cs_n = 1'b1;
    repeat (4) @(negedge clk);
    check("miso_oe after frame", 0, miso_oe);
  endtask

  task automatic query(input logic [7:0] op, input logic [7:0] exp, input string name);
    logic [7:0] rx;
    spi_xfer(op, rx);
    spi_xfer(8'hFF, rx);  // dummy byte that is no opcode
    exp_q.push_back(exp);
    got_q.push_back(rx);
    name_q.push_back(name);
  endtask

  task automatic send_with_param(input logic [7:0] op, input logic [7:0] param);
    logic [7:0] rx;
    spi_xfer(op, rx);
    spi_xfer(param, rx);
  endtask

  // one in or out cycle that also serves the esp side when esp_port is set
  task automatic z80_io(input logic [7:0] port, input logic is_out, input logic [7:0] wdata,
                        input logic esp_port);
    logic [31:0] r;
    int          n;
    r        = $urandom;
    addr     = {r[15:8], port};
    bus_d_in = wdata;
    ioreq_n  = 1'b0;
    if (is_out)
      out_n = 1'b0;
    else
      in_n = 1'b0;
    n = 0;
    if (esp_port) begin
      while (!bus_wait) begin
        @(negedge clk);
        n++;
        if (n > 20)
          abort_run("wait never went high after an esp port access");
      end
    end else begin
      repeat (4) @(negedge clk);  // strobe synchronised by now
    end
    wait_delay = n;
    cap_esp_s  = esp_s;
    cap_led    = led;
    cap_oe     = bus_d_oe;
    cap_ext    = extiosel;
    cap_data   = bus_d_out;
    if (esp_port) begin
      req_len = 0;
      while (esp_req) begin
        check("wait held during esp_req", 1, bus_wait);
        req_len++;
        if (req_len > ESP_REQ_CYCLES + 10)
          abort_run("esp_req stayed high too long");
        @(negedge clk);
      end
      repeat (3) begin
        check("wait held until esp_done", 1, bus_wait);
        @(negedge clk);
      end
      esp_done = 1'b1;
      done_lat = 0;
      while (bus_wait) begin
        @(negedge clk);
        done_lat++;
        if (done_lat > 10)
          abort_run("wait did not fall after esp_done");
      end
      esp_done = 1'b0;
    end else begin
      repeat (2) @(negedge clk);
    end
    in_n    = 1'b1;
    out_n   = 1'b1;
    ioreq_n = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    logic [31:0] r;
    logic [7:0]  val;
    logic [7:0]  st;
    int          n;
    void'($urandom(SEED));
    rst      = 1'b1;
    sck      = 1'b0;
    cs_n     = 1'b1;
    mosi     = 1'b0;
    addr     = 16'h0000;
    in_n     = 1'b1;
    out_n    = 1'b1;
    ioreq_n  = 1'b1;
    bus_d_in = 8'h00;
    esp_done = 1'b0;
    r        = $urandom;
    conf     = {1'b0, r[2:0]};  // bit 3 low selects model 3
    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);
    check("reset wait", 0, bus_wait);
    check("reset esp_req", 0, esp_req);
    check("reset int", 0, bus_int);
    check("reset flash_cs_n", 1, flash_cs_n);
    check("reset flash_sck", 0, flash_sck);
    check("reset bus_d_oe", 0, bus_d_oe);
    check("reset led_rgb", 0, led_rgb);

    $display("test 1: cookie, version, config");
    query(cmd_get_cookie, expected_reply(cmd_get_cookie, conf, bus_d_in, addr), "cookie");
    query(cmd_get_version, expected_reply(cmd_get_version, conf, bus_d_in, addr), "version");
    query(cmd_get_config, expected_reply(cmd_get_config, conf, bus_d_in, addr), "config");

    $display("test 2: frehd out with wait handshake");
    r = $urandom;
    z80_io({4'hC, r[3:0]}, 1'b1, r[15:8], 1'b1);
    check("frehd wait delay", 4, wait_delay);
    check("frehd esp_s", svc_frehd_out, cap_esp_s);
    check("led during frehd out", 4'b0111, cap_led);
    check("esp_req length", ESP_REQ_CYCLES, req_len);
    check("wait release within 4 cycles", 1, done_lat <= 4);

    $display("test 3: dbus_write then in 1Fh");
    r   = $urandom;
    val = r[7:0];
    send_with_param(cmd_dbus_write, val);
    z80_io(8'h1F, 1'b0, 8'h00, 1'b1);
    check("trs_io in bus_d_oe", 1, cap_oe);
    check("trs_io in extiosel", 1, cap_ext);
    check("trs_io in data", val, cap_data);
    check("trs_io in esp_s", svc_trs_io_in, cap_esp_s);

    $display("test 4: data ready interrupt");
    spi_xfer(cmd_data_ready, val);
    n = 0;
    while (!bus_int && n < 20) begin
      @(negedge clk);
      n++;
    end
    check("int set", 1, bus_int);
    z80_io(8'h1F, 1'b1, r[15:8], 1'b1);
    check("trs_io out esp_s", svc_trs_io_out, cap_esp_s);
    check("int cleared", 0, bus_int);

    $display("test 5: leds and esp status");
    repeat (2) begin
      r   = $urandom;
      val = r[7:0];
      st  = r[15:8];
      send_with_param(cmd_set_led, val);
      send_with_param(cmd_set_esp_status, st);
      check("led_rgb", val[2:0], led_rgb);
      check("led", {st[0], 1'b1, 2'b00}, led);
    end

    $display("test 6: flash spi");
    r          = $urandom;
    flash_byte = r[7:0];
    val        = r[15:8];
    z80_io(8'hFC, 1'b1, 8'h80, 1'b0);
    check("flash cs after FCh", 0, flash_cs_n);
    z80_io(8'hFD, 1'b1, val, 1'b0);
    n = 0;
    while (si_cnt < 8) begin
      @(negedge clk);
      n++;
      if (n > FLASH_CYCLES)
        abort_run("flash byte did not complete 8 sck periods");
    end
    repeat ((1 << FLASH_HALF_CYCLES_LOG2) + 4) @(negedge clk);
    check("flash si byte", val, si_bits);
    query(cmd_get_spi_data, flash_byte, "get_spi_data");
    z80_io(8'hFD, 1'b0, 8'h00, 1'b0);
    check("in FDh bus_d_oe", 1, cap_oe);
    check("in FDh data", flash_byte, cap_data);

    while (got_q.size() != 0)
      @(negedge clk);
    repeat (2) @(negedge clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* logic/trs_io_top.sv */
`timescale 1ns/1ps

module trs_io_top import host_pkg::*; #(
  parameter int ESP_REQ_CYCLES         = 50,
  parameter int FLASH_HALF_CYCLES_LOG2 = 3
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        sck,
  input  logic        cs_n,
  input  logic        mosi,
  output logic        miso,
  output logic        miso_oe,
  input  logic [15:0] addr,
  input  logic        in_n,
  input  logic        out_n,
  input  logic        ioreq_n,
  input  logic [7:0]  bus_d_in,
  output logic [7:0]  bus_d_out,
  output logic        bus_d_oe,
  input  logic [3:0]  conf,
  output logic [3:0]  esp_s,
  output logic        esp_req,
  input  logic        esp_done,
  output logic        bus_wait,
  output logic        bus_int,
  output logic        extiosel,
  output logic [3:0]  led,
  output logic [2:0]  led_rgb,
  output logic        flash_cs_n,
  output logic        flash_sck,
  output logic        flash_si,
  input  logic        flash_so
);

  logic [7:0] byte_in, byte_out, param0, trs_data, spi_rx, esp_status;
  logic       byte_valid, cmd_strobe, data_ready;
  cmd_e       cmd;
  logic       io_access, esp_sel_in, esp_sel_out, trs_io_hit;
  logic       spi_ctrl_wr, spi_data_wr, esp_start, mode_m3;

  assign mode_m3   = ~conf[3];  // jumper open selects model 3
  assign esp_start = io_access & (esp_sel_in | esp_sel_out);
  assign bus_int   = data_ready;
  assign led       = {esp_status[0], mode_m3, esp_sel_in | esp_sel_out, bus_wait};

  spi_link link_i (
    .clk(clk), .rst(rst), .sck(sck), .cs_n(cs_n), .mosi(mosi),
    .miso(miso), .miso_oe(miso_oe), .byte_out(byte_out),
    .byte_in(byte_in), .byte_valid(byte_valid)
  );

  cmd_parser parser_i (
    .clk(clk), .rst(rst), .byte_in(byte_in), .byte_valid(byte_valid),
    .cmd_strobe(cmd_strobe), .cmd(cmd), .param0(param0)
  );

  host_regs regs_i (
    .clk(clk), .rst(rst), .cmd_strobe(cmd_strobe), .cmd(cmd), .param0(param0),
    .abus_lo(addr[7:0]), .dbus(bus_d_in), .conf(conf), .spi_rx(spi_rx),
    .trs_io_hit(trs_io_hit), .io_access(io_access), .byte_out(byte_out),
    .trs_data(trs_data), .led_rgb(led_rgb), .esp_status(esp_status),
    .data_ready(data_ready)
  );

  io_decoder decoder_i (
    .clk(clk), .rst(rst), .addr(addr), .in_n(in_n), .out_n(out_n),
    .ioreq_n(ioreq_n), .mode_m3(mode_m3), .trs_data(trs_data), .spi_rx(spi_rx),
    .io_access(io_access), .esp_sel_in(esp_sel_in), .esp_sel_out(esp_sel_out),
    .esp_s(esp_s), .extiosel(extiosel), .trs_io_hit(trs_io_hit),
    .spi_ctrl_wr(spi_ctrl_wr), .spi_data_wr(spi_data_wr),
    .bus_d_oe(bus_d_oe), .bus_d_out(bus_d_out)
  );

  esp_handshake #(.ESP_REQ_CYCLES(ESP_REQ_CYCLES)) handshake_i (
    .clk(clk), .rst(rst), .esp_start(esp_start), .esp_done(esp_done),
    .bus_wait(bus_wait), .esp_req(esp_req)
  );

  flash_spi #(.FLASH_HALF_CYCLES_LOG2(FLASH_HALF_CYCLES_LOG2)) flash_i (
    .clk(clk), .rst(rst), .bus_d(bus_d_in), .spi_ctrl_wr(spi_ctrl_wr),
    .spi_data_wr(spi_data_wr), .cmd_strobe(cmd_strobe), .cmd(cmd),
    .param0(param0), .flash_so(flash_so), .spi_rx(spi_rx),
    .flash_cs_n(flash_cs_n), .flash_sck(flash_sck), .flash_si(flash_si)
  );

endmodule

/* logic/flash_spi.sv */
`timescale 1ns/1ps

module flash_spi import host_pkg::*; #(
  parameter int FLASH_HALF_CYCLES_LOG2 = 3
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] bus_d,
  input  logic       spi_ctrl_wr,
  input  logic       spi_data_wr,
  input  logic       cmd_strobe,
  input  cmd_e       cmd,
  input  logic [7:0] param0,
  input  logic       flash_so,
  output logic [7:0] spi_rx,
  output logic       flash_cs_n,
  output logic       flash_sck,
  output logic       flash_si
);

  // busy flag on top, then bit index, sck phase and sub-period count
  localparam int H  = FLASH_HALF_CYCLES_LOG2;
  localparam int CW = H + 5;
  localparam logic [CW-1:0] SUB_MASK = CW'((1 << H) - 1);

  logic          cs;
  logic [CW-1:0] cnt;
  logic [7:0]    shift;
  logic          busy;
  logic          phase_start;

  assign busy        = cnt[CW-1];
  assign phase_start = ((cnt & SUB_MASK) == '0);

  always_ff @(posedge clk) begin
    if (rst)
      cs <= 1'b0;
    else if (spi_ctrl_wr)
      cs <= bus_d[7];
    else if (cmd_strobe && cmd == cmd_set_spi_ctrl_reg)
      cs <= param0[7];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt      <= '0;
      flash_si <= 1'b0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;  // wraps to idle after the 8th bit
      if (phase_start && !cnt[H])
        flash_si <= shift[7];
    end else if (spi_data_wr || (cmd_strobe && cmd == cmd_set_spi_data)) begin
      cnt <= {1'b1, {(CW-1){1'b0}}};
    end
  end

  // shift data path, new loads ignored while busy
  always_ff @(posedge clk) begin
    if (busy) begin
      if (phase_start && cnt[H])
        shift <= {shift[6:0], flash_so};
    end else if (spi_data_wr) begin
      shift <= bus_d;
    end else if (cmd_strobe && cmd == cmd_set_spi_data) begin
      shift <= param0;
    end
  end

  assign spi_rx     = shift;
  assign flash_cs_n = ~cs;
  assign flash_sck  = cnt[H];

endmodule

/* logic/esp_handshake.sv */
`timescale 1ns/1ps

module esp_handshake #(
  parameter int ESP_REQ_CYCLES = 50
) (
  input  logic clk,
  input  logic rst,
  input  logic esp_start,
  input  logic esp_done,
  output logic bus_wait,
  output logic esp_req
);

  localparam int CW = $clog2(ESP_REQ_CYCLES + 1);

  logic [CW-1:0] req_cnt;
  logic [2:0]    done_r;
  logic          done_rise;

  assign done_rise = (done_r[2:1] == 2'b01);

  always_ff @(posedge clk) begin
    if (rst) begin
      req_cnt  <= '0;
      done_r   <= 3'b000;
      bus_wait <= 1'b0;
    end else begin
      done_r <= {done_r[1:0], esp_done};
      if (esp_start)
        req_cnt <= CW'(ESP_REQ_CYCLES);
      else if (req_cnt != '0)
        req_cnt <= req_cnt - 1'b1;
      // hold the z80 until the esp reports back
      if (esp_start)
        bus_wait <= 1'b1;
      else if (done_rise)
        bus_wait <= 1'b0;
    end
  end

  assign esp_req = (req_cnt != '0);

endmodule

/* logic/io_decoder.sv */
`timescale 1ns/1ps

module io_decoder import trs_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] addr,
  input  logic        in_n,
  input  logic        out_n,
  input  logic        ioreq_n,
  input  logic        mode_m3,
  input  logic [7:0]  trs_data,
  input  logic [7:0]  spi_rx,
  output logic        io_access,
  output logic        esp_sel_in,
  output logic        esp_sel_out,
  output logic [3:0]  esp_s,
  output logic        extiosel,
  output logic        trs_io_hit,
  output logic        spi_ctrl_wr,
  output logic        spi_data_wr,
  output logic        bus_d_oe,
  output logic [7:0]  bus_d_out
);

  logic       m3;
  logic       in_act;
  logic       out_act;
  logic [1:0] in_r;
  logic [1:0] out_r;
  logic [7:0] addr_r [2];
  logic       io_d;
  logic       in_s;
  logic       out_s;
  logic       trs_io_sel;
  logic       frehd_sel;
  logic       spi_data_rd;
  esp_svc_e   svc;

  // model 3 qualifies in/out with ioreq
  assign in_act  = m3 ? ~(in_n | ioreq_n) : ~in_n;
  assign out_act = m3 ? ~(out_n | ioreq_n) : ~out_n;

  always_ff @(posedge clk) begin
    addr_r[0] <= addr[7:0];
    addr_r[1] <= addr_r[0];
    if (rst) begin
      m3        <= 1'b0;
      in_r      <= 2'b00;
      out_r     <= 2'b00;
      io_d      <= 1'b0;
      io_access <= 1'b0;
    end else begin
      m3        <= mode_m3;
      in_r      <= {in_r[0], in_act};
      out_r     <= {out_r[0], out_act};
      io_d      <= in_s | out_s;
      io_access <= (in_s | out_s) & ~io_d;  // leading edge only
    end
  end

  assign in_s  = in_r[1];
  assign out_s = out_r[1];

  assign trs_io_sel = (addr_r[1] == PORT_TRS_IO);
  assign frehd_sel  = (addr_r[1][7:4] == PORT_FREHD_HI);

  assign esp_sel_in  = (trs_io_sel | frehd_sel) & in_s;
  assign esp_sel_out = (trs_io_sel | frehd_sel) & out_s;
  assign trs_io_hit  = trs_io_sel & (in_s | out_s);

  assign spi_ctrl_wr = io_access & out_s & (addr_r[1] == PORT_SPI_CTRL);
  assign spi_data_wr = io_access & out_s & (addr_r[1] == PORT_SPI_DATA);
  assign spi_data_rd = in_s & (addr_r[1] == PORT_SPI_DATA);

  always_comb begin
    if (trs_io_sel && in_s)
      svc = svc_trs_io_in;
    else if (trs_io_sel && out_s)
      svc = svc_trs_io_out;
    else if (frehd_sel && in_s)
      svc = svc_frehd_in;
    else if (frehd_sel && out_s)
      svc = svc_frehd_out;
    else
      svc = svc_idle;
  end

  assign esp_s = svc;

  // board answers the read, bus transceiver turns toward the z80
  assign extiosel  = esp_sel_in | spi_data_rd;
  assign bus_d_oe  = extiosel;
  assign bus_d_out = esp_sel_in  ? trs_data :
                     spi_data_rd ? spi_rx   : 8'h00;

endmodule

/* logic/host_regs.sv */
`timescale 1ns/1ps

module host_regs import host_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_strobe,
  input  cmd_e       cmd,
  input  logic [7:0] param0,
  input  logic [7:0] abus_lo,
  input  logic [7:0] dbus,
  input  logic [3:0] conf,
  input  logic [7:0] spi_rx,
  input  logic       trs_io_hit,
  input  logic       io_access,
  output logic [7:0] byte_out,
  output logic [7:0] trs_data,
  output logic [2:0] led_rgb,
  output logic [7:0] esp_status,
  output logic       data_ready
);

  // readback for the next spi frame, and the byte the z80 reads
  always_ff @(posedge clk) begin
    if (cmd_strobe) begin
      case (cmd)
        cmd_get_cookie:   byte_out <= COOKIE;
        cmd_get_version:  byte_out <= {VERSION_MAJOR, VERSION_MINOR};
        cmd_dbus_read:    byte_out <= dbus;
        cmd_abus_read:    byte_out <= abus_lo;
        cmd_get_config:   byte_out <= {4'b0000, conf};
        cmd_get_spi_data: byte_out <= spi_rx;
        cmd_dbus_write:   trs_data <= param0;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      led_rgb    <= 3'b000;
      esp_status <= 8'h00;
      data_ready <= 1'b0;
    end else begin
      if (cmd_strobe && cmd == cmd_set_led)
        led_rgb <= param0[2:0];  // red, green, blue from bit 0 up
      if (cmd_strobe && cmd == cmd_set_esp_status)
        esp_status <= param0;
      // z80 touching 1Fh acknowledges, a new command in the same cycle wins
      if (io_access && trs_io_hit)
        data_ready <= 1'b0;
      if (cmd_strobe && cmd == cmd_data_ready)
        data_ready <= 1'b1;
    end
  end

endmodule

/* logic/cmd_parser.sv */
`timescale 1ns/1ps

module cmd_parser import host_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] byte_in,
  input  logic       byte_valid,
  output logic       cmd_strobe,
  output cmd_e       cmd,
  output logic [7:0] param0
);

  parse_state_e state;
  logic [1:0]   bytes_left;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      cmd_strobe <= 1'b0;
      bytes_left <= 2'd0;
    end else begin
      cmd_strobe <= 1'b0;
      if (byte_valid) begin
        case (state)
          st_idle: begin
            case (byte_in)
              cmd_get_cookie, cmd_dbus_read, cmd_data_ready, cmd_get_version,
              cmd_abus_read, cmd_get_config, cmd_get_spi_data: begin
                cmd        <= cmd_e'(byte_in);
                cmd_strobe <= 1'b1;  // no parameters, fire now
              end
              cmd_dbus_write, cmd_set_led, cmd_set_spi_ctrl_reg,
              cmd_set_spi_data, cmd_set_esp_status: begin
                cmd        <= cmd_e'(byte_in);
                bytes_left <= 2'(NUM_PARAMS);
                state      <= st_read_bytes;
              end
              default: ;  // unknown opcode dropped
            endcase
          end
          st_read_bytes: begin
            param0 <= byte_in;
            if (bytes_left == 2'd1) begin
              cmd_strobe <= 1'b1;
              state      <= st_idle;
            end else begin
              bytes_left <= bytes_left - 2'd1;
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

endmodule

/* logic/spi_link.sv */
`timescale 1ns/1ps

module spi_link (
  input  logic       clk,
  input  logic       rst,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  output logic       miso_oe,
  input  logic [7:0] byte_out,
  output logic [7:0] byte_in,
  output logic       byte_valid
);

  logic [2:0] sck_r;
  logic [1:0] cs_r;
  logic [1:0] mosi_r;
  logic [2:0] bit_cnt;
  logic [7:0] tx_shift;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;

  assign sck_rise  = (sck_r[2:1] == 2'b01);
  assign sck_fall  = (sck_r[2:1] == 2'b10);
  assign cs_active = ~cs_r[1];

  always_ff @(posedge clk) begin
    mosi_r <= {mosi_r[0], mosi};
    if (rst) begin
      sck_r <= 3'b000;
      cs_r  <= 2'b11;  // deselected
    end else begin
      sck_r <= {sck_r[1:0], sck};
      cs_r  <= {cs_r[0], cs_n};
    end
  end

  // receive side, msb first
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt    <= 3'd0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= 3'd0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7)
          byte_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      byte_in <= {byte_in[6:0], mosi_r[1]};
    // reply is picked up after the first bit of the frame
    if (cs_active && sck_fall) begin
      if (bit_cnt == 3'd1)
        tx_shift <= byte_out;
      else
        tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign miso    = tx_shift[7];
  assign miso_oe = cs_active;

endmodule

/* logic/host_pkg.sv */
package host_pkg;

  // opcodes sent by the esp over the spi link
  typedef enum logic [7:0] {
    cmd_get_cookie       = 8'd0,
    cmd_dbus_read        = 8'd3,
    cmd_dbus_write       = 8'd4,
    cmd_data_ready       = 8'd5,
    cmd_get_version      = 8'd15,
    cmd_abus_read        = 8'd18,
    cmd_set_led          = 8'd26,
    cmd_get_config       = 8'd27,
    cmd_set_spi_ctrl_reg = 8'd29,
    cmd_set_spi_data     = 8'd30,
    cmd_get_spi_data     = 8'd31,
    cmd_set_esp_status   = 8'd32
  } cmd_e;

  typedef enum logic {
    st_idle,
    st_read_bytes
  } parse_state_e;

  localparam logic [7:0] COOKIE        = 8'hAF;
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  // longest parameter list of any opcode
  localparam int NUM_PARAMS = 1;

endpackage

/* logic/trs_pkg.sv */
package trs_pkg;

  // z80 i/o ports served by the board
  localparam logic [7:0] PORT_TRS_IO   = 8'h1F;
  localparam logic [3:0] PORT_FREHD_HI = 4'hC;  // C0h..CFh
  localparam logic [7:0] PORT_SPI_CTRL = 8'hFC;
  localparam logic [7:0] PORT_SPI_DATA = 8'hFD;

  // service code on esp_s, all ones when nothing is pending
  typedef enum logic [3:0] {
    svc_trs_io_in  = 4'd0,
    svc_trs_io_out = 4'd1,
    svc_frehd_in   = 4'd2,
    svc_frehd_out  = 4'd3,
    svc_idle       = 4'hF
  } esp_svc_e;

endpackage
